// ==== src.f ====
+incdir+testbench
hw/spi_ctl_pkg.sv
hw/spi_slave_frontend.sv
hw/ctl_reg_file.sv
hw/periph_router.sv
hw/heartbeat_gray.sv
hw/spi_ctl_top.sv
testbench/tb_spi_ctl.sv

// ==== testbench/spi_ctl_model.svh ====
//////////////////////////////////////////////////////////////////////
// reference rules for register update, mux select and readback
// included inside the testbench module, needs spi_ctl_pkg compiled
//////////////////////////////////////////////////////////////////////

`ifndef SPI_CTL_MODEL_SVH
`define SPI_CTL_MODEL_SVH

// any bit in both nibbles turns the whole write into a toggle
function automatic logic [3:0] model_bits
(
  input logic [3:0]            old_val,
  input spi_ctl_pkg::bit_cmd_t cmd
);
  logic [3:0] result;
  logic       toggle_mode;
  toggle_mode = |(cmd.set & cmd.clear);
  for (int b = 0; b < 4; b++)
  begin
    if (toggle_mode)
      result[b] = (cmd.set[b] && cmd.clear[b]) ? ~old_val[b] : old_val[b];
    else if (cmd.clear[b])
      result[b] = 1'b0;
    else
      result[b] = cmd.set[b] ? 1'b1 : old_val[b];
  end
  return result;
endfunction

// index 1..8 picks one peripheral, else none
function automatic logic [7:0] model_select(input logic [7:0] sel);
  logic [7:0] result;
  for (int b = 0; b < 8; b++)
    result[b] = (sel == b + 1);
  return result;
endfunction

function automatic spi_ctl_pkg::ctl_regs_t model_apply
(
  input spi_ctl_pkg::ctl_regs_t   old_regs,
  input spi_ctl_pkg::spi_frame_t  f
);
  spi_ctl_pkg::ctl_regs_t r;
  r = old_regs;
  case (f.addr)
    8'd7:  r.led = model_bits(old_regs.led, f.data.bits);
    8'd8:  r.mux = model_select(f.data.sel);
    8'd9:  r.dac = model_bits(old_regs.dac, f.data.bits);
    8'd14: r.adc = model_bits(old_regs.adc, f.data.bits);
    8'd11: r = '0;
    8'd6:
    begin
      r.led = 4'd0;
      r.adc = 4'd0;
    end
    default: r = old_regs;
  endcase
  return r;
endfunction

// value seen on miso in the data byte, taken before the write
function automatic logic [7:0] model_readback
(
  input spi_ctl_pkg::ctl_regs_t r,
  input logic [7:0]             addr
);
  if (addr == 8'd7)
    return {4'd0, r.led};
  if (addr == 8'd8)
    return r.mux;
  if (addr == 8'd9)
    return {4'd0, r.dac};
  if (addr == 8'd14)
    return {4'd0, r.adc};
  return 8'd0;
endfunction

`endif

// ==== testbench/tb_spi_ctl.sv ====
//////////////////////////////////////////////////////////////////////
// random spi frames checked against the register model
// plus routing, pass-through and heartbeat checks
// heartbeat delay is fixed at 2**3 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_spi_ctl;

  // random writes, short frames, mux sweep
  localparam int num_frames     = 300 + 20 + 9;
  localparam int timeout_cycles = num_frames * 400 + 2000;
  localparam int half_period    = 10;

  logic       clk;
  logic       rst;
  logic       sclk;
  logic       cs;
  logic       mosi;
  logic       cs2;
  logic [7:0] periph_miso;
  logic       adc_drdy;
  logic       miso;
  logic [7:0] periph_cs;
  logic       periph_sclk;
  logic       periph_mosi;
  logic [3:0] led;
  logic [3:0] dac_ctl;
  logic [3:0] adc_ctl;
  logic [3:0] hb;
  logic       irq;

  spi_ctl_pkg::ctl_regs_t model_regs;
  int                     error_count;
  int                     check_count;
  int                     test_count;
  int                     cycle_count;

  `include "spi_ctl_model.svh"

  spi_ctl_top #(
    .HB_LOG2DELAY (3)
  ) u_spi_ctl_top (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .cs2         (cs2),
    .periph_miso (periph_miso),
    .adc_drdy    (adc_drdy),
    .miso        (miso),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl),
    .hb          (hb),
    .irq         (irq)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // mux only visible on periph_cs while cs2 is low
  task automatic check_regs(input spi_ctl_pkg::ctl_regs_t expected);
    spi_ctl_pkg::ctl_regs_t actual;
    cs2 <= 1'b0;
    @(posedge clk);
    actual.led = led;
    actual.mux = ~periph_cs;
    actual.dac = dac_ctl;
    actual.adc = adc_ctl;
    cs2 <= 1'b1;
    check_byte("led", {4'd0, expected.led}, {4'd0, actual.led});
    check_byte("mux", expected.mux, actual.mux);
    check_byte("dac_ctl", {4'd0, expected.dac}, {4'd0, actual.dac});
    check_byte("adc_ctl", {4'd0, expected.adc}, {4'd0, actual.adc});
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int start_errors);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - start_errors);
  endtask

  ////////////////////////////////////////////////////////////////////
  // spi master in mode 0 with msb first
  // called on a rising clk edge and returns once the registers settled

  task automatic send_frame(input logic [15:0] word, input int nbits,
                            output logic [7:0] rx);
    rx = 8'd0;
    cs <= 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi <= word[15 - i];
      repeat (half_period) @(posedge clk);
      // data byte comes back on bits 9 to 16
      if (i >= 8)
        rx = {rx[6:0], miso};
      sclk <= 1'b1;
      repeat (half_period) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (half_period) @(posedge clk);
    cs <= 1'b1;
    // registers follow 4 cycles after cs rises
    repeat (4) @(posedge clk);
  endtask

  task automatic run_frame(input spi_ctl_pkg::spi_frame_t f);
    logic [7:0] rx;
    send_frame(f, 16, rx);
    check_byte("readback", model_readback(model_regs, f.addr), rx);
    model_regs = model_apply(model_regs, f);
    check_regs(model_regs);
  endtask

  // defined addresses plus a few with no register behind them
  function automatic logic [7:0] random_addr();
    case ($urandom_range(0, 9))
      0: return spi_ctl_pkg::addr_led;
      1: return spi_ctl_pkg::addr_mux;
      2: return spi_ctl_pkg::addr_dac;
      3: return spi_ctl_pkg::addr_adc;
      4: return spi_ctl_pkg::addr_soft_reset;
      5: return spi_ctl_pkg::addr_powerup;
      6: return 8'd0;
      7: return 8'd3;
      8: return 8'd10;
      default: return 8'd200;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////
  // watchdog

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not end within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    spi_ctl_pkg::spi_frame_t f;
    logic [7:0]              rx;
    logic [3:0]              prev_hb;
    logic                    exp_miso;
    int                      start_errors;
    int                      last_change;
    int                      changes;
    void'($urandom(32'h6cf1_8334));
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    rst         = 1'b1;
    sclk        = 1'b0;
    cs          = 1'b1;
    mosi        = 1'b0;
    cs2         = 1'b1;
    periph_miso = 8'd0;
    adc_drdy    = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // reset values
    start_errors   = error_count;
    model_regs.led = 4'd0;
    model_regs.mux = 8'd0;
    model_regs.dac = 4'b1111;
    model_regs.adc = 4'd0;
    check_byte("periph_cs", 8'hff, periph_cs);
    check_regs(model_regs);
    report_test("reset_values", start_errors);

    // random writes with readback of the old value on each
    start_errors = error_count;
    for (int n = 0; n < 300; n++)
    begin
      f.addr = random_addr();
      // keep mux indices mostly in range
      if (f.addr == spi_ctl_pkg::addr_mux && $urandom_range(0, 3) != 0)
        f.data.sel = $urandom_range(0, 9);
      else
        f.data.sel = $urandom;
      run_frame(f);
    end
    report_test("random_writes_readback", start_errors);

    // cut-off frames must leave everything alone
    start_errors = error_count;
    for (int n = 0; n < 20; n++)
    begin
      send_frame($urandom, $urandom_range(1, 15), rx);
      check_regs(model_regs);
    end
    report_test("short_frames", start_errors);

    // every mux index followed by random return lines with cs2 low
    start_errors = error_count;
    for (int s = 0; s <= 8; s++)
    begin
      f.addr     = spi_ctl_pkg::addr_mux;
      f.data.sel = s;
      run_frame(f);
      for (int k = 0; k < 8; k++)
      begin
        periph_miso <= $urandom;
        cs2         <= 1'b0;
        @(posedge clk);
        // high when some selected peripheral drives its return line high
        exp_miso = 1'b0;
        for (int b = 0; b < 8; b++)
          if (model_regs.mux[b] && periph_miso[b])
            exp_miso = 1'b1;
        check_bit("miso", exp_miso, miso);
        check_byte("periph_cs", ~model_regs.mux, periph_cs);
      end
      cs2 <= 1'b1;
      @(posedge clk);
    end
    report_test("routing", start_errors);

    // pass-through lines with cs high so the frontend ignores sclk
    start_errors = error_count;
    for (int k = 0; k < 32; k++)
    begin
      sclk     <= $urandom;
      mosi     <= $urandom;
      adc_drdy <= $urandom;
      @(posedge clk);
      check_bit("periph_sclk", sclk, periph_sclk);
      check_bit("periph_mosi", mosi, periph_mosi);
      check_bit("irq", adc_drdy, irq);
    end
    sclk     <= 1'b0;
    mosi     <= 1'b0;
    adc_drdy <= 1'b0;
    @(posedge clk);
    report_test("pass_through", start_errors);

    // heartbeat sampled mid-cycle
    start_errors = error_count;
    @(negedge clk);
    prev_hb     = hb;
    last_change = -1;
    changes     = 0;
    for (int c = 0; c < 100; c++)
    begin
      @(negedge clk);
      if (hb !== prev_hb)
      begin
        if ($countones(hb ^ prev_hb) != 1)
          note_failure($sformatf("hb went from %b to %b, more than one bit", prev_hb, hb));
        if (last_change >= 0 && c - last_change != 8)
          note_failure($sformatf("hb steps came %0d cycles apart, not 8", c - last_change));
        last_change = c;
        changes++;
        prev_hb = hb;
      end
    end
    if (changes < 10)
      note_failure("hb stopped stepping");
    @(posedge clk);
    report_test("heartbeat", start_errors);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/spi_ctl_top.sv ====
//////////////////////////////////////////////////////////////////////
// spi control-plane top, one spi port for registers and peripherals
// cs selects the register bank, cs2 routes to the muxed peripheral
// sclk, mosi and adc_drdy pass straight through
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_ctl_top
#(
  parameter int HB_LOG2DELAY = 20
)
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               sclk,
  input  logic                               cs,
  input  logic                               mosi,
  input  logic                               cs2,
  input  logic [spi_ctl_pkg::num_periph-1:0] periph_miso,
  input  logic                               adc_drdy,
  output logic                               miso,
  output logic [spi_ctl_pkg::num_periph-1:0] periph_cs,
  output logic                               periph_sclk,
  output logic                               periph_mosi,
  output logic [3:0]                         led,
  output logic [3:0]                         dac_ctl,
  output logic [3:0]                         adc_ctl,
  output logic [3:0]                         hb,
  output logic                               irq
);

  logic                    sdo;
  logic [7:0]              rd_addr;
  logic [7:0]              rd_data;
  logic                    frame_valid;
  spi_ctl_pkg::spi_frame_t frame;
  spi_ctl_pkg::ctl_regs_t  regs;

  ////////////////////////////////////////////////////////////////////
  // pass-through

  // peripherals share the controller's spi clock and data
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;
  // adc data ready is the host interrupt
  assign irq         = adc_drdy;

  assign led     = regs.led;
  assign dac_ctl = regs.dac;
  assign adc_ctl = regs.adc;

  ////////////////////////////////////////////////////////////////////
  // instances

  spi_slave_frontend u_frontend
  (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .sdo         (sdo),
    .rd_addr     (rd_addr),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  ctl_reg_file u_reg_file
  (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .regs        (regs)
  );

  periph_router u_router
  (
    .cs2         (cs2),
    .sdo         (sdo),
    .mux         (regs.mux),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

  heartbeat_gray #(
    .LOG2DELAY (HB_LOG2DELAY)
  ) u_heartbeat (
    .clk (clk),
    .rst (rst),
    .hb  (hb)
  );

endmodule

`default_nettype wire

// ==== hw/heartbeat_gray.sv ====
//////////////////////////////////////////////////////////////////////
// free-running heartbeat, hb steps every 2**LOG2DELAY cycles
// gray coded so only one indicator changes per step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module heartbeat_gray
#(
  parameter int LOG2DELAY = 20
)
(
  input  logic       clk,
  input  logic       rst,
  output logic [3:0] hb
);

  logic [LOG2DELAY+3:0] counter;
  logic [3:0]           slow;

  // top four counter bits
  assign slow = counter[LOG2DELAY+3:LOG2DELAY];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      counter <= '0;
      hb      <= 4'd0;
    end
    else
    begin
      counter <= counter + 1'b1;
      // binary to gray
      hb      <= slow ^ (slow >> 1);
    end
  end

endmodule

`default_nettype wire

// ==== hw/periph_router.sv ====
//////////////////////////////////////////////////////////////////////
// purely combinational steering of chip selects and return data
// cs2 high means idle, the controller itself drives miso
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module periph_router
(
  input  logic                               cs2,
  input  logic                               sdo,
  input  logic [spi_ctl_pkg::num_periph-1:0] mux,
  input  logic [spi_ctl_pkg::num_periph-1:0] periph_miso,
  output logic [spi_ctl_pkg::num_periph-1:0] periph_cs,
  output logic                               miso
);

  always_comb
  begin
    if (cs2)
    begin
      // all peripherals deselected
      periph_cs = '1;
      miso      = sdo;
    end
    else
    begin
      // active low selects follow the one-hot mux
      periph_cs = ~mux;
      // any selected return line high
      miso      = |(mux & periph_miso);
    end
  end

endmodule

`default_nettype wire

// ==== hw/ctl_reg_file.sv ====
//////////////////////////////////////////////////////////////////////
// control registers, updated one cycle after frame_valid
// readback is combinational and shows the value before any write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctl_reg_file
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    frame_valid,
  input  spi_ctl_pkg::spi_frame_t frame,
  input  logic [7:0]              rd_addr,
  output logic [7:0]              rd_data,
  output spi_ctl_pkg::ctl_regs_t  regs
);

  ////////////////////////////////////////////////////////////////////
  // update rules

  // set and clear nibbles
  // bits in both nibbles toggle instead
  function automatic logic [3:0] apply_bits
  (
    input logic [3:0]            old_val,
    input spi_ctl_pkg::bit_cmd_t cmd
  );
    logic [3:0] both;
    both = cmd.set & cmd.clear;
    if (both != 4'b0000)
      return old_val ^ both;
    return (old_val | cmd.set) & ~cmd.clear;
  endfunction

  // one-hot peripheral select
  // index 0 and anything past the last peripheral deselect all
  function automatic logic [7:0] sel_onehot
  (
    input logic [7:0] sel
  );
    logic [7:0] onehot;
    onehot = 8'd0;
    if (sel != 8'd0 && sel <= spi_ctl_pkg::num_periph)
      onehot = 8'd1 << (sel - 8'd1);
    return onehot;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // register write

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regs.led <= 4'd0;
      regs.mux <= 8'd0;
      regs.dac <= spi_ctl_pkg::dac_reset;
      regs.adc <= 4'd0;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        spi_ctl_pkg::addr_led:
          regs.led <= apply_bits(regs.led, frame.data.bits);
        spi_ctl_pkg::addr_mux:
          regs.mux <= sel_onehot(frame.data.sel);
        spi_ctl_pkg::addr_dac:
          regs.dac <= apply_bits(regs.dac, frame.data.bits);
        spi_ctl_pkg::addr_adc:
          regs.adc <= apply_bits(regs.adc, frame.data.bits);
        spi_ctl_pkg::addr_soft_reset:
        begin
          regs.led <= 4'd0;
          regs.mux <= 8'd0;
          regs.dac <= 4'd0;
          regs.adc <= 4'd0;
        end
        spi_ctl_pkg::addr_powerup:
        begin
          // dac already configured before the rails, left alone
          regs.led <= 4'd0;
          regs.adc <= 4'd0;
        end
        default:
        begin
          // undefined address, nothing written
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // readback mux

  always_comb
  begin
    case (rd_addr)
      spi_ctl_pkg::addr_led: rd_data = {4'd0, regs.led};
      spi_ctl_pkg::addr_mux: rd_data = regs.mux;
      spi_ctl_pkg::addr_dac: rd_data = {4'd0, regs.dac};
      spi_ctl_pkg::addr_adc: rd_data = {4'd0, regs.adc};
      default:               rd_data = 8'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/spi_slave_frontend.sv ====
//////////////////////////////////////////////////////////////////////
// spi mode 0 slave, pins sampled by clk and never used as a clock
// sclk half period must be at least 8 clk cycles
// only frames of exactly 16 sclk rising edges are strobed out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_slave_frontend
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sclk,
  input  logic                   cs,
  input  logic                   mosi,
  input  logic [7:0]             rd_data,
  output logic                   sdo,
  output logic [7:0]             rd_addr,
  output logic                   frame_valid,
  output spi_ctl_pkg::spi_frame_t frame
);

  ////////////////////////////////////////////////////////////////////
  // pin synchronizers
  // bit 2 of sclk and cs is the previous value for edge detect

  logic [2:0]  sclk_sync;
  logic [2:0]  cs_sync;
  logic [1:0]  mosi_sync;
  logic        sclk_rise;
  logic        sclk_fall;
  logic        cs_rise;
  logic        cs_active;
  logic [4:0]  bit_cnt;
  logic [15:0] shift_in;
  logic [7:0]  shift_out;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // cs idles high, so no false end of frame out of reset
      sclk_sync <= 3'b000;
      cs_sync   <= 3'b111;
      mosi_sync <= 2'b00;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_active = ~cs_sync[1];

  ////////////////////////////////////////////////////////////////////
  // receive side

  // bit count saturates so long frames never look like 16
  always_ff @(posedge clk)
  begin
    if (rst || !cs_active)
      bit_cnt <= 5'd0;
    else if (sclk_rise && bit_cnt != 5'd31)
      bit_cnt <= bit_cnt + 5'd1;
  end

  // msb first, shift toward msb
  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
      shift_in <= {shift_in[14:0], mosi_sync[1]};
  end

  // address byte latched on the 8th rising edge
  always_ff @(posedge clk)
  begin
    if (rst)
      rd_addr <= 8'd0;
    else if (cs_active && sclk_rise && bit_cnt == 5'd7)
      rd_addr <= {shift_in[6:0], mosi_sync[1]};
  end

  // end of frame strobe, dropped unless exactly 16 bits came in
  always_ff @(posedge clk)
  begin
    if (rst)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && (bit_cnt == 5'd16);
  end

  always_ff @(posedge clk)
  begin
    if (cs_rise)
      frame <= shift_in;
  end

  ////////////////////////////////////////////////////////////////////
  // transmit side
  // first byte is zero, second byte is the readback value

  always_ff @(posedge clk)
  begin
    if (rst || !cs_active)
    begin
      sdo       <= 1'b0;
      shift_out <= 8'd0;
    end
    else if (sclk_fall)
    begin
      if (bit_cnt == 5'd8)
      begin
        // falling edge after the address byte
        sdo       <= rd_data[7];
        shift_out <= {rd_data[6:0], 1'b0};
      end
      else
      begin
        sdo       <= shift_out[7];
        shift_out <= {shift_out[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/spi_ctl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types and constants for the spi control-plane controller
// frames are 16 bits, address byte first, msb first on the wire
// register widths are fixed at 4 bits except the 8 bit mux
//////////////////////////////////////////////////////////////////////

`default_nettype none

package spi_ctl_pkg;

  ////////////////////////////////////////////////////////////////////
  // register and command addresses

  localparam logic [7:0] addr_led        = 8'd7;
  localparam logic [7:0] addr_mux        = 8'd8;
  localparam logic [7:0] addr_dac        = 8'd9;
  localparam logic [7:0] addr_adc        = 8'd14;

  // clears led, mux, dac and adc
  localparam logic [7:0] addr_soft_reset = 8'd11;
  // clears led and adc only, dac is set up before rails come up
  localparam logic [7:0] addr_powerup    = 8'd6;

  ////////////////////////////////////////////////////////////////////
  // sizes and reset values

  // routed downstream peripherals
  localparam int num_periph = 8;

  // dac control lines idle high
  localparam logic [3:0] dac_reset = 4'b1111;

  ////////////////////////////////////////////////////////////////////
  // frame and register types

  // set and clear nibbles, both bits high means toggle
  typedef struct packed {
    logic [3:0] clear;
    logic [3:0] set;
  } bit_cmd_t;

  // data byte, bit commands or a mux select index
  typedef union packed {
    bit_cmd_t   bits;
    logic [7:0] sel;
  } reg_data_u;

  // first byte on the wire is the address
  typedef struct packed {
    logic [7:0] addr;
    reg_data_u  data;
  } spi_frame_t;

  // all control registers
  typedef struct packed {
    logic [3:0] led;
    logic [7:0] mux;
    logic [3:0] dac;
    logic [3:0] adc;
  } ctl_regs_t;

endpackage

`default_nettype wire
